// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int XLEN      = 32;

    // Field widths
    localparam int ECODE_W      = 6;
    localparam int ESUBCODE_W   = 9;
    localparam int PLV_W        = 2;
    localparam int LIE_W        = 13;
    localparam int TCFG_INITV_W = 30;
    localparam int EENTRY_VA_W  = 26;

    // Field positions
    localparam int CRMD_PLV_LSB      = 0;
    localparam int CRMD_IE_BIT       = 2;
    localparam int CRMD_DA_BIT       = 3;
    localparam int PRMD_PIE_BIT      = 2;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITV_LSB    = 2;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int ESTAT_TI_BIT      = 11;
    localparam int ESTAT_ECODE_LSB   = 16;
    localparam int ESTAT_ESUB_LSB    = 22;

    // Counter value for a stopped timer
    localparam logic [XLEN-1:0] TIMER_IDLE = {XLEN{1'b1}};

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h00,
        CSR_PRMD   = 14'h01,
        CSR_ECFG   = 14'h04,
        CSR_ESTAT  = 14'h05,
        CSR_ERA    = 14'h06,
        CSR_EENTRY = 14'h0c,
        CSR_SAVE0  = 14'h30,
        CSR_SAVE1  = 14'h31,
        CSR_SAVE2  = 14'h32,
        CSR_SAVE3  = 14'h33,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_addr_e;

endpackage

// ==== rtl/csr_except_regs.sv ====
`timescale 1ns/1ps

module csr_except_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           csr_we,
    input  csr_pkg::csr_addr_e             csr_num,
    input  logic [csr_pkg::XLEN-1:0]       csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]       csr_wvalue,
    input  logic                           wb_ex,
    input  logic [csr_pkg::XLEN-1:0]       wb_pc,
    input  logic [csr_pkg::ECODE_W-1:0]    wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0] wb_esubcode,
    input  logic                           ertn_flush,
    output logic [csr_pkg::PLV_W-1:0]      crmd_plv,
    output logic                           crmd_ie,
    output logic                           crmd_da,
    output logic [csr_pkg::PLV_W-1:0]      prmd_pplv,
    output logic                           prmd_pie,
    output logic [csr_pkg::XLEN-1:0]       era,
    output logic [csr_pkg::EENTRY_VA_W-1:0] eentry_va,
    output logic [csr_pkg::ECODE_W-1:0]    estat_ecode,
    output logic [csr_pkg::ESUBCODE_W-1:0] estat_esubcode,
    output logic [csr_pkg::XLEN-1:0]       ex_entry,
    output logic [csr_pkg::XLEN-1:0]       ertn_entry
);
    import csr_pkg::*;

    logic crmd_we;
    logic prmd_we;
    logic era_we;
    logic eentry_we;

    assign crmd_we   = csr_we && (csr_num == CSR_CRMD);
    assign prmd_we   = csr_we && (csr_num == CSR_PRMD);
    assign era_we    = csr_we && (csr_num == CSR_ERA);
    assign eentry_we = csr_we && (csr_num == CSR_EENTRY);

    // Exception beats return, return beats a CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (crmd_we) begin
            crmd_plv <= (csr_wmask[CRMD_PLV_LSB +: PLV_W] & csr_wvalue[CRMD_PLV_LSB +: PLV_W])
                      | (~csr_wmask[CRMD_PLV_LSB +: PLV_W] & crmd_plv);
            crmd_ie  <= csr_wmask[CRMD_IE_BIT] ? csr_wvalue[CRMD_IE_BIT] : crmd_ie;
        end
    end

    // DA stays set, the core runs untranslated
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (prmd_we) begin
            prmd_pplv <= (csr_wmask[PLV_W-1:0] & csr_wvalue[PLV_W-1:0])
                       | (~csr_wmask[PLV_W-1:0] & prmd_pplv);
            prmd_pie  <= csr_wmask[PRMD_PIE_BIT] ? csr_wvalue[PRMD_PIE_BIT] : prmd_pie;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era            <= wb_pc;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (era_we) begin
            era <= (csr_wmask & csr_wvalue) | (~csr_wmask & era);
        end
    end

    always_ff @(posedge clk) begin
        if (eentry_we) begin
            eentry_va <= (csr_wmask[XLEN-1 -: EENTRY_VA_W] & csr_wvalue[XLEN-1 -: EENTRY_VA_W])
                       | (~csr_wmask[XLEN-1 -: EENTRY_VA_W] & eentry_va);
        end
    end

    assign ex_entry   = {eentry_va, {(XLEN - EENTRY_VA_W){1'b0}}};
    assign ertn_entry = era;

endmodule

// ==== rtl/csr_intr_ctrl.sv ====
`timescale 1ns/1ps

module csr_intr_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       csr_we,
    input  csr_pkg::csr_addr_e         csr_num,
    input  logic [csr_pkg::XLEN-1:0]   csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]   csr_wvalue,
    input  logic                       crmd_ie,
    input  logic                       timer_pending,
    output logic [1:0]                 estat_swi,
    output logic [csr_pkg::LIE_W-1:0]  ecfg_lie,
    output logic                       has_int
);
    import csr_pkg::*;

    logic [LIE_W-1:0] int_status;

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_swi <= 2'b00;
            ecfg_lie  <= '0;
        end else if (csr_we && (csr_num == CSR_ESTAT)) begin
            estat_swi <= (csr_wmask[1:0] & csr_wvalue[1:0]) | (~csr_wmask[1:0] & estat_swi);
        end else if (csr_we && (csr_num == CSR_ECFG)) begin
            ecfg_lie <= (csr_wmask[LIE_W-1:0] & csr_wvalue[LIE_W-1:0])
                      | (~csr_wmask[LIE_W-1:0] & ecfg_lie);
        end
    end

    // Hardware and IPI lines are not wired, only SWI and timer
    always_comb begin
        int_status               = '0;
        int_status[1:0]          = estat_swi;
        int_status[ESTAT_TI_BIT] = timer_pending;
    end

    assign has_int = crmd_ie && |(int_status[ESTAT_TI_BIT:0] & ecfg_lie[ESTAT_TI_BIT:0]);

endmodule

// ==== rtl/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              csr_we,
    input  csr_pkg::csr_addr_e                csr_num,
    input  logic [csr_pkg::XLEN-1:0]          csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]          csr_wvalue,
    output logic                              tcfg_en,
    output logic                              tcfg_periodic,
    output logic [csr_pkg::TCFG_INITV_W-1:0]  tcfg_initval,
    output logic [csr_pkg::XLEN-1:0]          timer_cnt,
    output logic                              timer_pending
);
    import csr_pkg::*;

    logic            tcfg_we;
    logic            ticlr_clr;
    logic [XLEN-1:0] tcfg_next;

    assign tcfg_we   = csr_we && (csr_num == CSR_TCFG);
    assign ticlr_clr = csr_we && (csr_num == CSR_TICLR)
                    && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];

    // TCFG after the masked write, also used to load the counter
    assign tcfg_next = (csr_wmask & csr_wvalue)
                     | (~csr_wmask & {tcfg_initval, tcfg_periodic, tcfg_en});

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_next[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[TCFG_INITV_LSB +: TCFG_INITV_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= TIMER_IDLE;
        end else if (tcfg_we && tcfg_next[TCFG_EN_BIT]) begin
            timer_cnt <= {tcfg_next[TCFG_INITV_LSB +: TCFG_INITV_W], 2'b00};
        end else if (tcfg_en && (timer_cnt != TIMER_IDLE)) begin
            if ((timer_cnt == '0) && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Set wins over a TICLR clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (tcfg_en && (timer_cnt == '0)) begin
            timer_pending <= 1'b1;
        end else if (ticlr_clr) begin
            timer_pending <= 1'b0;
        end
    end

endmodule

// ==== rtl/csr_save_regs.sv ====
`timescale 1ns/1ps

module csr_save_regs (
    input  logic                      clk,
    input  logic                      csr_we,
    input  csr_pkg::csr_addr_e        csr_num,
    input  logic [csr_pkg::XLEN-1:0]  csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]  csr_wvalue,
    output logic [csr_pkg::XLEN-1:0]  save0,
    output logic [csr_pkg::XLEN-1:0]  save1,
    output logic [csr_pkg::XLEN-1:0]  save2,
    output logic [csr_pkg::XLEN-1:0]  save3
);
    import csr_pkg::*;

    logic [XLEN-1:0] save_q [4];

    // SAVE0..SAVE3 sit at consecutive numbers
    for (genvar i = 0; i < 4; i++) begin : g_save
        localparam logic [CSR_NUM_W-1:0] NUM = CSR_SAVE0 + i;

        always_ff @(posedge clk) begin
            if (csr_we && (csr_num == NUM)) begin
                save_q[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save_q[i]);
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// ==== rtl/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_addr_e                csr_num,
    input  logic [csr_pkg::PLV_W-1:0]         crmd_plv,
    input  logic                              crmd_ie,
    input  logic                              crmd_da,
    input  logic [csr_pkg::PLV_W-1:0]         prmd_pplv,
    input  logic                              prmd_pie,
    input  logic [csr_pkg::XLEN-1:0]          era,
    input  logic [csr_pkg::EENTRY_VA_W-1:0]   eentry_va,
    input  logic [csr_pkg::ECODE_W-1:0]       estat_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]    estat_esubcode,
    input  logic [1:0]                        estat_swi,
    input  logic [csr_pkg::LIE_W-1:0]         ecfg_lie,
    input  logic                              tcfg_en,
    input  logic                              tcfg_periodic,
    input  logic [csr_pkg::TCFG_INITV_W-1:0]  tcfg_initval,
    input  logic [csr_pkg::XLEN-1:0]          timer_cnt,
    input  logic                              timer_pending,
    input  logic [csr_pkg::XLEN-1:0]          save0,
    input  logic [csr_pkg::XLEN-1:0]          save1,
    input  logic [csr_pkg::XLEN-1:0]          save2,
    input  logic [csr_pkg::XLEN-1:0]          save3,
    output logic [csr_pkg::XLEN-1:0]          csr_rvalue
);
    import csr_pkg::*;

    // Reserved bits stay zero, TICLR and unknown numbers read zero
    always_comb begin
        csr_rvalue = '0;
        case (csr_num)
            CSR_CRMD: begin
                csr_rvalue[CRMD_PLV_LSB +: PLV_W] = crmd_plv;
                csr_rvalue[CRMD_IE_BIT]           = crmd_ie;
                csr_rvalue[CRMD_DA_BIT]           = crmd_da;
            end
            CSR_PRMD: begin
                csr_rvalue[PLV_W-1:0]   = prmd_pplv;
                csr_rvalue[PRMD_PIE_BIT] = prmd_pie;
            end
            CSR_ECFG:   csr_rvalue[LIE_W-1:0] = ecfg_lie;
            CSR_ESTAT: begin
                csr_rvalue[1:0]                            = estat_swi;
                csr_rvalue[ESTAT_TI_BIT]                   = timer_pending;
                csr_rvalue[ESTAT_ECODE_LSB +: ECODE_W]     = estat_ecode;
                csr_rvalue[ESTAT_ESUB_LSB +: ESUBCODE_W]   = estat_esubcode;
            end
            CSR_ERA:    csr_rvalue = era;
            CSR_EENTRY: csr_rvalue[XLEN-1 -: EENTRY_VA_W] = eentry_va;
            CSR_SAVE0:  csr_rvalue = save0;
            CSR_SAVE1:  csr_rvalue = save1;
            CSR_SAVE2:  csr_rvalue = save2;
            CSR_SAVE3:  csr_rvalue = save3;
            CSR_TCFG:   csr_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
            CSR_TVAL:   csr_rvalue = timer_cnt;
            default:    csr_rvalue = '0;
        endcase
    end

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         csr_we,
    input  csr_pkg::csr_addr_e           csr_num,
    input  logic [csr_pkg::XLEN-1:0]     csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]     csr_wvalue,
    input  logic                         wb_ex,
    input  logic [csr_pkg::XLEN-1:0]     wb_pc,
    input  logic [csr_pkg::ECODE_W-1:0]  wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0] wb_esubcode,
    input  logic                         ertn_flush,
    output logic [csr_pkg::XLEN-1:0]     csr_rvalue,
    output logic [csr_pkg::XLEN-1:0]     ex_entry,
    output logic [csr_pkg::XLEN-1:0]     ertn_entry,
    output logic                         has_int
);
    import csr_pkg::*;

    logic [PLV_W-1:0]        crmd_plv;
    logic                    crmd_ie;
    logic                    crmd_da;
    logic [PLV_W-1:0]        prmd_pplv;
    logic                    prmd_pie;
    logic [XLEN-1:0]         era;
    logic [EENTRY_VA_W-1:0]  eentry_va;
    logic [ECODE_W-1:0]      estat_ecode;
    logic [ESUBCODE_W-1:0]   estat_esubcode;
    logic [1:0]              estat_swi;
    logic [LIE_W-1:0]        ecfg_lie;
    logic                    tcfg_en;
    logic                    tcfg_periodic;
    logic [TCFG_INITV_W-1:0] tcfg_initval;
    logic [XLEN-1:0]         timer_cnt;
    logic                    timer_pending;
    logic [XLEN-1:0]         save0;
    logic [XLEN-1:0]         save1;
    logic [XLEN-1:0]         save2;
    logic [XLEN-1:0]         save3;

    csr_except_regs except_i (.*);

    csr_intr_ctrl intr_i (.*);

    csr_timer timer_i (.*);

    csr_save_regs save_i (
        .clk        (clk),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3)
    );

    csr_read_mux read_mux_i (.*);

endmodule

// ==== verif/csr_unit_properties.sv ====
`timescale 1ns/1ps

module csr_unit_properties (
    input logic                          clk,
    input logic                          reset,
    input logic                          csr_we,
    input csr_pkg::csr_addr_e            csr_num,
    input logic                          wb_ex,
    input logic                          has_int,
    input logic                          crmd_ie,
    input logic [csr_pkg::PLV_W-1:0]     crmd_plv,
    input logic                          tcfg_en,
    input logic [csr_pkg::XLEN-1:0]      timer_cnt
);
    import csr_pkg::*;

    // Interrupts are masked by CRMD.IE
    assert property (@(posedge clk) disable iff (reset) has_int |-> crmd_ie)
        else $error("has_int is high while CRMD.IE is clear");

    assert property (@(posedge clk) disable iff (reset) wb_ex |=> (crmd_plv == '0 && !crmd_ie))
        else $error("PLV or IE not cleared after an exception");

    // A stopped timer only moves on a TCFG write
    assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !(csr_we && csr_num == CSR_TCFG)) |=> $stable(timer_cnt))
        else $error("timer counter changed while the timer is disabled");

endmodule

bind csr_unit csr_unit_properties props_i (
    .clk       (clk),
    .reset     (reset),
    .csr_we    (csr_we),
    .csr_num   (csr_num),
    .wb_ex     (wb_ex),
    .has_int   (has_int),
    .crmd_ie   (crmd_ie),
    .crmd_plv  (crmd_plv),
    .tcfg_en   (tcfg_en),
    .timer_cnt (timer_cnt)
);

// ==== verif/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [ECODE_W-1:0]    EXC_ECODE = 6'h0b;
    localparam logic [ESUBCODE_W-1:0] EXC_ESUB  = 9'h005;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_EXCEPT, OP_ERTN, OP_IDLE} op_e;

    // Exception rows carry the codes in mask[14:0] and the PC in value
    typedef struct packed {
        op_e         op;
        csr_addr_e   num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] expected;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  csr_we;
    csr_addr_e             csr_num;
    logic [XLEN-1:0]       csr_wmask;
    logic [XLEN-1:0]       csr_wvalue;
    logic                  wb_ex;
    logic [XLEN-1:0]       wb_pc;
    logic [ECODE_W-1:0]    wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    logic                  ertn_flush;
    logic [XLEN-1:0]       csr_rvalue;
    logic [XLEN-1:0]       ex_entry;
    logic [XLEN-1:0]       ertn_entry;
    logic                  has_int;

    row_t        table_q[$];
    logic [31:0] shadow [64];
    logic [31:0] lcg_state = 32'h6935e545;
    logic [31:0] exc_pc;
    logic [31:0] estat_codes;
    int          value_errors = 0;
    int          timeout_errors = 0;

    csr_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic row_t make_row(op_e op, csr_addr_e num, logic [31:0] mask,
                                      logic [31:0] value, logic [31:0] expected);
        row_t r;
        r.op       = op;
        r.num      = num;
        r.mask     = mask;
        r.value    = value;
        r.expected = expected;
        return r;
    endfunction

    function automatic logic [31:0] writable_bits(csr_addr_e num);
        case (num)
            CSR_EENTRY: return 32'hffff_ffc0;
            CSR_ECFG:   return 32'h0000_1fff;
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endfunction

    // Masked write, then a read-back of the merged value
    function automatic void push_masked_write(csr_addr_e num, logic [31:0] mask,
                                              logic [31:0] value);
        shadow[int'(num)] = ((shadow[int'(num)] & ~mask) | (value & mask)) & writable_bits(num);
        table_q.push_back(make_row(OP_WRITE, num, mask, value, '0));
        table_q.push_back(make_row(OP_READ, num, '0, '0, shadow[int'(num)]));
    endfunction

    function automatic void build_table();
        csr_addr_e regs [6];
        regs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_EENTRY, CSR_ECFG};
        table_q.push_back(make_row(OP_READ, CSR_CRMD, '0, '0, 32'h8));
        table_q.push_back(make_row(OP_READ, CSR_TVAL, '0, '0, 32'hffff_ffff));
        foreach (regs[i]) begin
            push_masked_write(regs[i], 32'hffff_ffff, lcg_next());
            repeat (3) push_masked_write(regs[i], lcg_next(), lcg_next());
        end
        // PLV 3 and IE 1 before the exception
        table_q.push_back(make_row(OP_WRITE, CSR_CRMD, 32'h7, 32'h7, '0));
        table_q.push_back(make_row(OP_READ, CSR_CRMD, '0, '0, 32'hf));
        exc_pc      = lcg_next() & ~32'h3;
        estat_codes = (32'(EXC_ESUB) << ESTAT_ESUB_LSB) | (32'(EXC_ECODE) << ESTAT_ECODE_LSB);
        table_q.push_back(make_row(OP_EXCEPT, CSR_CRMD, {17'd0, EXC_ESUB, EXC_ECODE}, exc_pc, '0));
        table_q.push_back(make_row(OP_READ, CSR_PRMD, '0, '0, 32'h7));
        table_q.push_back(make_row(OP_READ, CSR_CRMD, '0, '0, 32'h8));
        table_q.push_back(make_row(OP_READ, CSR_ERA, '0, '0, exc_pc));
        table_q.push_back(make_row(OP_READ, CSR_ESTAT, '0, '0, estat_codes));
        table_q.push_back(make_row(OP_ERTN, CSR_CRMD, '0, '0, '0));
        table_q.push_back(make_row(OP_READ, CSR_CRMD, '0, '0, 32'hf));
        table_q.push_back(make_row(OP_IDLE, CSR_CRMD, '0, '0, '0));
    endfunction

    task automatic apply_row(row_t r);
        @(posedge clk);
        csr_we     <= 1'b0;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
        csr_num    <= r.num;
        case (r.op)
            OP_WRITE: begin
                csr_we     <= 1'b1;
                csr_wmask  <= r.mask;
                csr_wvalue <= r.value;
            end
            OP_EXCEPT: begin
                wb_ex       <= 1'b1;
                wb_pc       <= r.value;
                wb_ecode    <= r.mask[5:0];
                wb_esubcode <= r.mask[14:6];
            end
            OP_ERTN: ertn_flush <= 1'b1;
            default: ;
        endcase
        @(negedge clk);
        if (r.op == OP_READ) begin
            check_value($sformatf("csr_rvalue[%s]", r.num.name()), csr_rvalue, r.expected);
        end
    endtask

    task automatic write_csr(csr_addr_e num, logic [31:0] mask, logic [31:0] value);
        apply_row(make_row(OP_WRITE, num, mask, value, '0));
    endtask

    task automatic read_csr(csr_addr_e num, logic [31:0] exp);
        apply_row(make_row(OP_READ, num, '0, '0, exp));
    endtask

    task automatic wait_read_bit(csr_addr_e num, int bit_pos, logic level, int limit,
                                 string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            apply_row(make_row(OP_IDLE, num, '0, '0, '0));
            seen = (csr_rvalue[bit_pos] === level);
            n++;
        end
        assert (seen) else begin
            timeout_errors++;
            $display("timeout: %s did not happen within %0d cycles", what, limit);
        end
    endtask

    initial begin
        reset       = 1'b1;
        csr_we      = 1'b0;
        csr_num     = CSR_CRMD;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_pc       = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        ertn_flush  = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        build_table();
        foreach (table_q[i]) apply_row(table_q[i]);
        check_value("ex_entry", ex_entry, shadow[int'(CSR_EENTRY)]);
        check_value("ertn_entry", ertn_entry, exc_pc);

        // One-shot timer, INITV 3 gives 12 ticks
        write_csr(CSR_ECFG, 32'h1fff, 32'h0);
        write_csr(CSR_TCFG, 32'hffff_ffff, (32'd3 << TCFG_INITV_LSB) | 32'h1);
        for (int k = 0; k <= 12; k++) read_csr(CSR_TVAL, 32'd12 - 32'(k));
        wait_read_bit(CSR_ESTAT, ESTAT_TI_BIT, 1'b1, 4, "one-shot timer pending");
        read_csr(CSR_TVAL, 32'hffff_ffff);
        check_value("has_int", 32'(has_int), 32'h0);
        write_csr(CSR_ECFG, 32'h1fff, 32'h800);
        read_csr(CSR_ESTAT, estat_codes | 32'h800);
        check_value("has_int", 32'(has_int), 32'h1);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, estat_codes);
        check_value("has_int", 32'(has_int), 32'h0);

        // Periodic timer sets pending again after a clear
        write_csr(CSR_TCFG, 32'hffff_ffff, (32'd2 << TCFG_INITV_LSB) | 32'h3);
        wait_read_bit(CSR_ESTAT, ESTAT_TI_BIT, 1'b1, 20, "periodic timer pending");
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        wait_read_bit(CSR_ESTAT, ESTAT_TI_BIT, 1'b0, 4, "timer pending clear");
        wait_read_bit(CSR_ESTAT, ESTAT_TI_BIT, 1'b1, 20, "timer pending after reload");
        // Reloaded to 8 on the pending edge, one tick since
        read_csr(CSR_TVAL, 32'd7);
        write_csr(CSR_TCFG, 32'h1, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, estat_codes);

        // Software interrupt bit 0
        write_csr(CSR_ECFG, 32'h1fff, 32'h1);
        read_csr(CSR_ECFG, 32'h1);
        check_value("has_int", 32'(has_int), 32'h0);
        write_csr(CSR_ESTAT, 32'h3, 32'h1);
        read_csr(CSR_ESTAT, estat_codes | 32'h1);
        check_value("has_int", 32'(has_int), 32'h1);

        $display("checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
rtl/csr_pkg.sv
rtl/csr_except_regs.sv
rtl/csr_intr_ctrl.sv
rtl/csr_timer.sv
rtl/csr_save_regs.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
verif/csr_unit_properties.sv
verif/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)
